// File: include/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// integer datapath width
`define EXEC_XLEN 32

// one iteration per result bit in the multiply/divide loop
`define EXEC_STEPS 32

// opcode field width, must hold every exec_op_e value
`define EXEC_OPW 5

`endif

// File: verilog/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

    typedef enum logic [`EXEC_OPW-1:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_lui,
        op_sll,
        op_srl,
        op_sra,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo
    } exec_op_e;

    typedef struct packed {
        exec_op_e              op;
        logic [`EXEC_XLEN-1:0] src1;
        logic [`EXEC_XLEN-1:0] src2;
    } exec_req_t;

    // same 64 bits, read as product or as remainder/quotient
    typedef union packed {
        struct packed {
            logic [`EXEC_XLEN-1:0] hi;
            logic [`EXEC_XLEN-1:0] lo;
        } prod;
        struct packed {
            logic [`EXEC_XLEN-1:0] rem;
            logic [`EXEC_XLEN-1:0] quot;
        } quo;
    } md_word_u;

    typedef enum logic [1:0] {
        md_mul,
        md_div,
        md_none
    } md_kind_e;

endpackage

// File: verilog/alu_logic.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module alu_logic (
    input  exec_pkg::exec_req_t    req,
    output logic [`EXEC_XLEN-1:0]  alu_result,
    output logic                   overflow
);
    import exec_pkg::*;

    localparam int XL = `EXEC_XLEN;

    logic          sub_mode;
    logic [XL-1:0] adder_b;
    logic [XL-1:0] sum;
    logic          carry_out;
    logic          slt_bit;
    logic          sltu_bit;
    logic [4:0]    shamt;

    // sub, subu and both compares go through the adder as a - b
    assign sub_mode = (req.op == op_sub) || (req.op == op_subu) ||
                      (req.op == op_slt) || (req.op == op_sltu);

    assign adder_b = sub_mode ? ~req.src2 : req.src2;
    assign {carry_out, sum} = {1'b0, req.src1} + {1'b0, adder_b} + {{XL{1'b0}}, sub_mode};

    // signs differ: a is less when a is negative, else look at the difference
    assign slt_bit = (req.src1[XL-1] & ~req.src2[XL-1]) |
                     (~(req.src1[XL-1] ^ req.src2[XL-1]) & sum[XL-1]);
    assign sltu_bit = ~carry_out; // borrow out of a - b

    assign shamt = req.src1[4:0];

    // operands agree in sign (after inversion for sub) but sum does not
    always_comb begin
        overflow = 1'b0;
        if ((req.op == op_add) || (req.op == op_sub)) begin
            overflow = (req.src1[XL-1] == adder_b[XL-1]) && (sum[XL-1] != req.src1[XL-1]);
        end
    end

    always_comb begin
        case (req.op)
            op_add, op_addu, op_sub, op_subu: alu_result = sum;
            op_slt:  alu_result = {{(XL-1){1'b0}}, slt_bit};
            op_sltu: alu_result = {{(XL-1){1'b0}}, sltu_bit};
            op_and:  alu_result = req.src1 & req.src2;
            op_or:   alu_result = req.src1 | req.src2;
            op_nor:  alu_result = ~(req.src1 | req.src2);
            op_xor:  alu_result = req.src1 ^ req.src2;
            op_lui:  alu_result = {req.src2[15:0], 16'b0};
            op_sll:  alu_result = req.src2 << shamt;
            op_srl:  alu_result = req.src2 >> shamt;
            op_sra:  alu_result = $signed(req.src2) >>> shamt;
            default: alu_result = '0; // hi/lo reads are muxed in the top level
        endcase
    end

endmodule

// File: verilog/muldiv_ctrl.sv
`timescale 1ns/1ns

module muldiv_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  exec_pkg::exec_op_e req_op,
    input  logic               issue,
    input  logic               last_step,
    output exec_pkg::md_kind_e kind,
    output logic               start_step,
    output logic               step_en,
    output logic               fixup,
    output logic               busy,
    output logic               done
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fixup,
        st_finish
    } state_e;

    state_e state;
    state_e state_next;
    logic   is_mul;
    logic   is_div;

    assign is_mul = (req_op == op_mult) || (req_op == op_multu);
    assign is_div = (req_op == op_div) || (req_op == op_divu);

    // issue only counts when idle, later ones are dropped
    assign start_step = (state == st_idle) && issue && (is_mul || is_div);

    always_comb begin
        state_next = state;
        case (state)
            st_idle:   if (start_step) state_next = st_run;
            st_run:    if (last_step) state_next = st_fixup;
            st_fixup:  state_next = st_finish;
            st_finish: state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            kind  <= md_none;
        end else begin
            state <= state_next;
            if (start_step) kind <= is_mul ? md_mul : md_div;
        end
    end

    assign step_en = (state == st_run);
    assign fixup   = (state == st_fixup);
    assign busy    = (state == st_run) || (state == st_fixup); // low again once done shows
    assign done    = (state == st_finish);

endmodule

// File: verilog/step_counter.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module step_counter (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic en,
    output logic last_step
);

    localparam int CW = $clog2(`EXEC_STEPS);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= CW'(`EXEC_STEPS - 1);
        end else if (en) begin
            count <= count - 1'b1;
        end
    end

    // final iteration of the loop
    assign last_step = en && (count == '0);

endmodule

// File: verilog/muldiv_datapath.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module muldiv_datapath (
    input  logic               clk,
    input  logic               reset,
    input  exec_pkg::exec_req_t req,
    input  logic               start_step,
    input  logic               step_en,
    input  logic               fixup,
    input  exec_pkg::md_kind_e kind,
    output exec_pkg::md_word_u md_word
);
    import exec_pkg::*;

    localparam int XL = `EXEC_XLEN;

    logic [XL-1:0]   acc_hi;   // partial product high half / remainder
    logic [XL-1:0]   acc_lo;   // multiplier bits / dividend bits then quotient
    logic [XL-1:0]   opnd;     // multiplicand or divisor magnitude
    logic            neg_main; // product or quotient must be negated
    logic            neg_rem;  // remainder follows dividend sign
    logic            signed_op;
    logic            s1_neg;
    logic            s2_neg;
    logic [XL-1:0]   mag1;
    logic [XL-1:0]   mag2;
    logic [XL-1:0]   addend;
    logic [XL:0]     add_sum;
    logic [XL:0]     rem_shift;
    logic [XL:0]     sub_diff;
    logic [2*XL-1:0] full_neg;

    assign signed_op = (req.op == op_mult) || (req.op == op_div);
    assign s1_neg    = signed_op && req.src1[XL-1];
    assign s2_neg    = signed_op && req.src2[XL-1];
    assign mag1      = s1_neg ? -req.src1 : req.src1;
    assign mag2      = s2_neg ? -req.src2 : req.src2;

    // multiply step, add multiplicand when the low multiplier bit is set
    assign addend  = acc_lo[0] ? opnd : '0;
    assign add_sum = {1'b0, acc_hi} + {1'b0, addend};

    // divide step, shift in the next dividend bit and try the subtract
    assign rem_shift = {acc_hi, acc_lo[XL-1]};
    assign sub_diff  = rem_shift - {1'b0, opnd}; // msb set means it did not fit

    assign full_neg = -{acc_hi, acc_lo};

    always_ff @(posedge clk) begin
        if (reset) begin
            neg_main <= 1'b0;
            neg_rem  <= 1'b0;
        end else if (start_step) begin
            neg_main <= s1_neg ^ s2_neg;
            neg_rem  <= s1_neg;
        end
    end

    // multiply is commutative so both ops load src1 into acc_lo
    always_ff @(posedge clk) begin
        if (start_step) begin
            acc_hi <= '0;
            acc_lo <= mag1;
            opnd   <= mag2;
        end else if (step_en) begin
            if (kind == md_mul) begin
                acc_hi <= add_sum[XL:1];
                acc_lo <= {add_sum[0], acc_lo[XL-1:1]};
            end else begin
                acc_hi <= sub_diff[XL] ? rem_shift[XL-1:0] : sub_diff[XL-1:0];
                acc_lo <= {acc_lo[XL-2:0], ~sub_diff[XL]};
            end
        end else if (fixup) begin
            if (kind == md_mul) begin
                if (neg_main) {acc_hi, acc_lo} <= full_neg;
            end else begin
                if (neg_main) acc_lo <= -acc_lo;
                if (neg_rem) acc_hi <= -acc_hi;
            end
        end
    end

    // hi or rem in the upper half, lo or quot in the lower
    assign md_word = {acc_hi, acc_lo};

endmodule

// File: verilog/hilo_regs.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module hilo_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  exec_pkg::md_word_u    md_word,
    input  logic                  md_write,
    input  exec_pkg::md_kind_e    kind,
    input  exec_pkg::exec_req_t   req,
    input  logic                  commit_block,
    output logic [`EXEC_XLEN-1:0] hi,
    output logic [`EXEC_XLEN-1:0] lo
);
    import exec_pkg::*;

    // a blocked commit means a later stage faulted, nothing lands
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (!commit_block) begin
            if (md_write) begin
                case (kind)
                    md_mul: begin
                        hi <= md_word.prod.hi;
                        lo <= md_word.prod.lo;
                    end
                    md_div: begin
                        hi <= md_word.quo.rem; // remainder to hi
                        lo <= md_word.quo.quot;
                    end
                    default: ;
                endcase
            end else if (req.op == op_mthi) begin
                hi <= req.src1;
            end else if (req.op == op_mtlo) begin
                lo <= req.src1;
            end
        end
    end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  exec_pkg::exec_req_t   req,
    input  logic                  issue,
    input  logic                  commit_block,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  overflow,
    output logic                  busy,
    output logic                  done
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] hi;
    logic [`EXEC_XLEN-1:0] lo;
    md_kind_e              kind;
    md_word_u              md_word;
    logic                  start_step;
    logic                  step_en;
    logic                  fixup;
    logic                  last_step;

    alu_logic u_alu_logic (
        .req        (req),
        .alu_result (alu_result),
        .overflow   (overflow)
    );

    muldiv_ctrl u_muldiv_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req_op     (req.op),
        .issue      (issue),
        .last_step  (last_step),
        .kind       (kind),
        .start_step (start_step),
        .step_en    (step_en),
        .fixup      (fixup),
        .busy       (busy),
        .done       (done)
    );

    step_counter u_step_counter (
        .clk       (clk),
        .reset     (reset),
        .load      (start_step),
        .en        (step_en),
        .last_step (last_step)
    );

    muldiv_datapath u_muldiv_datapath (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .start_step (start_step),
        .step_en    (step_en),
        .fixup      (fixup),
        .kind       (kind),
        .md_word    (md_word)
    );

    // done cycle doubles as the hi/lo write strobe
    hilo_regs u_hilo_regs (
        .clk          (clk),
        .reset        (reset),
        .md_word      (md_word),
        .md_write     (done),
        .kind         (kind),
        .req          (req),
        .commit_block (commit_block),
        .hi           (hi),
        .lo           (lo)
    );

    always_comb begin
        case (req.op)
            op_mfhi: result = hi;
            op_mflo: result = lo;
            default: result = alu_result;
        endcase
    end

endmodule

// File: tests/exec_unit_asserts.sv
`timescale 1ns/1ns

module exec_unit_asserts (
    input logic clk,
    input logic reset,
    input logic start_step,
    input logic busy,
    input logic done
);

    // done never lasts two cycles
    property done_one_cycle;
        @(posedge clk) disable iff (reset) done |=> !done;
    endproperty

    // accepted issue at edge N, done in the 34th cycle after it
    property done_latency;
        @(posedge clk) disable iff (reset) start_step |=> !done [*33] ##1 done;
    endproperty

    // busy through the run, then low in the done cycle
    property busy_until_done;
        @(posedge clk) disable iff (reset) start_step |=> busy [*33] ##1 (done && !busy);
    endproperty

    assert property (done_one_cycle)
        else $error("done held high for more than one cycle");
    assert property (done_latency)
        else $error("done not seen 34 cycles after an accepted issue");
    assert property (busy_until_done)
        else $error("busy not held until done, or busy and done high together");

endmodule

bind muldiv_ctrl exec_unit_asserts u_exec_unit_asserts (
    .clk        (clk),
    .reset      (reset),
    .start_step (start_step),
    .busy       (busy),
    .done       (done)
);

// File: tests/exec_unit_tb.sv
`timescale 1ns/1ns
`include "exec_params.svh"

module exec_unit_tb;
    import exec_pkg::*;

    logic                  clk;
    logic                  reset;
    exec_req_t             req;
    logic                  issue;
    logic                  commit_block;
    logic [`EXEC_XLEN-1:0] result;
    logic                  overflow;
    logic                  busy;
    logic                  done;
    int                    errors;
    int                    checks;
    int                    tests;
    integer                seed;

    exec_unit u_exec_unit (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .issue        (issue),
        .commit_block (commit_block),
        .result       (result),
        .overflow     (overflow),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] model_alu(input exec_op_e op, input logic [31:0] a, b);
        case (op)
            op_add, op_addu: model_alu = a + b;
            op_sub, op_subu: model_alu = a - b;
            op_slt:  model_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu: model_alu = (a < b) ? 32'd1 : 32'd0;
            op_and:  model_alu = a & b;
            op_or:   model_alu = a | b;
            op_nor:  model_alu = ~(a | b);
            op_xor:  model_alu = a ^ b;
            op_lui:  model_alu = {b[15:0], 16'h0};
            op_sll:  model_alu = b << a[4:0];
            op_srl:  model_alu = b >> a[4:0];
            op_sra:  model_alu = $signed(b) >>> a[4:0];
            default: model_alu = 32'h0;
        endcase
    endfunction

    function automatic logic model_ovf(input exec_op_e op, input logic [31:0] a, b);
        logic [31:0] r;
        r = model_alu(op, a, b);
        if (op == op_add) model_ovf = (a[31] == b[31]) && (r[31] != a[31]);
        else if (op == op_sub) model_ovf = (a[31] != b[31]) && (r[31] != a[31]);
        else model_ovf = 1'b0;
    endfunction

    // 64-bit product, signed via sign extension
    function automatic logic [63:0] model_mul(input exec_op_e op, input logic [31:0] a, b);
        logic [63:0] ea;
        logic [63:0] eb;
        ea = (op == op_mult) ? {{32{a[31]}}, a} : {32'h0, a};
        eb = (op == op_mult) ? {{32{b[31]}}, b} : {32'h0, b};
        model_mul = ea * eb;
    endfunction

    // {rem, quot}, magnitudes first then sign fixup
    function automatic logic [63:0] model_div(input exec_op_e op, input logic [31:0] a, b);
        logic        sa;
        logic        sb;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        sa = (op == op_div) && a[31];
        sb = (op == op_div) && b[31];
        ma = sa ? -a : a;
        mb = sb ? -b : b;
        if (mb == 32'h0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (sa ^ sb) q = -q;
        if (sa) r = -r; // remainder follows the dividend
        model_div = {r, q};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apply(input exec_op_e op, input logic [31:0] a, b);
        @(posedge clk);
        req <= '{op, a, b};
    endtask

    task automatic check_single(input exec_op_e op, input logic [31:0] a, b);
        apply(op, a, b);
        @(negedge clk);
        check_word({op.name(), " result"}, result, model_alu(op, a, b));
        check_word({op.name(), " overflow"}, {31'b0, overflow}, {31'b0, model_ovf(op, a, b)});
    endtask

    task automatic read_hilo(output logic [31:0] hi, lo);
        apply(op_mfhi, 32'h0, 32'h0);
        @(negedge clk);
        hi = result;
        apply(op_mflo, 32'h0, 32'h0);
        @(negedge clk);
        lo = result;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < 60) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout at t=%0t, done never came after the issue", $time);
            errors++;
        end
    endtask

    // issue one op, commit_block held at blk until the hi/lo write edge
    task automatic run_muldiv(input exec_op_e op, input logic [31:0] a, b, input logic blk);
        @(posedge clk);
        req <= '{op, a, b};
        issue <= 1'b1;
        commit_block <= blk;
        @(posedge clk);
        issue <= 1'b0;
        wait_done();
        @(posedge clk); // hi/lo written on this edge
        commit_block <= 1'b0;
    endtask

    task automatic check_muldiv(input exec_op_e op, input logic [31:0] a, b);
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] exp;
        exp = (op == op_mult || op == op_multu) ? model_mul(op, a, b) : model_div(op, a, b);
        run_muldiv(op, a, b, 1'b0);
        read_hilo(hi, lo);
        check_word({op.name(), " hi"}, hi, exp[63:32]);
        check_word({op.name(), " lo"}, lo, exp[31:0]);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset();
        logic [31:0] hi;
        logic [31:0] lo;
        int          e0;
        e0 = errors;
        read_hilo(hi, lo);
        check_word("busy", {31'b0, busy}, 32'h0);
        check_word("done", {31'b0, done}, 32'h0);
        check_word("hi", hi, 32'h0);
        check_word("lo", lo, 32'h0);
        finish_test("reset", e0);
    endtask

    task automatic test_single_cycle();
        logic [31:0] corners [6] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000,
                                     32'hffffffff, 32'h0000001f};
        int          e0;
        e0 = errors;
        for (int k = 0; k <= 13; k++) begin // op_add through op_sra
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) check_single(exec_op_e'(k), corners[i], corners[j]);
            end
            for (int n = 0; n < 20; n++) check_single(exec_op_e'(k), $random(seed), $random(seed));
        end
        finish_test("single_cycle", e0);
    endtask

    task automatic check_overflow(input exec_op_e op, input logic [31:0] a, b, input logic exp);
        apply(op, a, b);
        @(negedge clk);
        check_word({op.name(), " overflow"}, {31'b0, overflow}, {31'b0, exp});
    endtask

    task automatic test_overflow();
        int e0;
        e0 = errors;
        check_overflow(op_add, 32'h7fffffff, 32'h1, 1'b1);
        check_overflow(op_add, 32'h80000000, 32'hffffffff, 1'b1);
        check_overflow(op_add, 32'h7fffffff, 32'hffffffff, 1'b0);
        check_overflow(op_sub, 32'h80000000, 32'h1, 1'b1);
        check_overflow(op_sub, 32'h7fffffff, 32'hffffffff, 1'b1);
        check_overflow(op_sub, 32'h0, 32'h80000000, 1'b1);
        check_overflow(op_sub, 32'h5, 32'h7, 1'b0);
        check_overflow(op_addu, 32'h7fffffff, 32'h1, 1'b0);
        check_overflow(op_subu, 32'h80000000, 32'h1, 1'b0);
        check_overflow(op_slt, 32'h80000000, 32'h1, 1'b0);
        check_overflow(op_sltu, 32'h0, 32'hffffffff, 1'b0);
        finish_test("overflow", e0);
    endtask

    task automatic test_multiply();
        logic [31:0] pa [5] = '{32'd3, 32'hfffffffd, 32'hfffffff9, 32'h80000000, 32'hffffffff};
        logic [31:0] pb [5] = '{32'd5, 32'd5, 32'hfffffff7, 32'h80000000, 32'hffffffff};
        int          e0;
        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            check_muldiv(op_mult, pa[i], pb[i]);
            check_muldiv(op_multu, pa[i], pb[i]);
        end
        for (int n = 0; n < 4; n++) begin
            check_muldiv(op_mult, $random(seed), $random(seed));
            check_muldiv(op_multu, $random(seed), $random(seed));
        end
        finish_test("multiply", e0);
    endtask

    task automatic test_divide();
        logic [31:0] da [7] = '{32'd100, -32'd100, 32'd100, -32'd100, 32'd5, -32'd5, 32'h80000000};
        logic [31:0] db [7] = '{32'd7, 32'd7, -32'd7, -32'd7, 32'd0, 32'd0, 32'hffffffff};
        int          e0;
        e0 = errors;
        for (int i = 0; i < 7; i++) begin
            check_muldiv(op_div, da[i], db[i]);
            check_muldiv(op_divu, da[i], db[i]);
        end
        for (int n = 0; n < 4; n++) begin
            check_muldiv(op_div, $random(seed), $random(seed) & 32'h8000ffff);
            check_muldiv(op_divu, $random(seed), $random(seed) & 32'h0000ffff);
        end
        finish_test("divide", e0);
    endtask

    task automatic test_hilo_writes();
        logic [31:0] hi;
        logic [31:0] lo;
        int          e0;
        e0 = errors;
        apply(op_mthi, 32'h12345678, 32'h0);
        apply(op_mtlo, 32'h9abcdef0, 32'h0);
        read_hilo(hi, lo);
        check_word("hi", hi, 32'h12345678);
        check_word("lo", lo, 32'h9abcdef0);
        @(posedge clk);
        req <= '{op_mthi, 32'hdeadbeef, 32'h0};
        commit_block <= 1'b1;
        @(posedge clk); // blocked mthi sampled here
        req <= '{op_add, 32'h0, 32'h0};
        commit_block <= 1'b0;
        read_hilo(hi, lo);
        check_word("hi", hi, 32'h12345678);
        run_muldiv(op_mult, 32'd3, 32'd4, 1'b1);
        read_hilo(hi, lo);
        check_word("hi", hi, 32'h12345678);
        check_word("lo", lo, 32'h9abcdef0);
        check_muldiv(op_mult, 32'd3, 32'd4);
        finish_test("hilo_writes", e0);
    endtask

    task automatic test_busy_ignore();
        logic [31:0] hi;
        logic [31:0] lo;
        int          e0;
        e0 = errors;
        @(posedge clk);
        req <= '{op_mult, 32'd6, 32'd7};
        issue <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        @(posedge clk);
        req <= '{op_divu, 32'd100, 32'd3}; // second issue lands while busy
        issue <= 1'b1;
        @(negedge clk);
        check_word("busy", {31'b0, busy}, 32'h1);
        @(posedge clk);
        issue <= 1'b0;
        wait_done();
        @(posedge clk);
        read_hilo(hi, lo);
        check_word("hi", hi, 32'h0);
        check_word("lo", lo, 32'd42);
        check_word("busy", {31'b0, busy}, 32'h0);
        finish_test("busy_ignore", e0);
    endtask

    initial begin
        reset = 1'b1;
        issue = 1'b0;
        commit_block = 1'b0;
        req = '{op_add, 32'h0, 32'h0};
        errors = 0;
        checks = 0;
        tests = 0;
        seed = 32'h94e0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_single_cycle();
        test_overflow();
        test_multiply();
        test_divide();
        test_hilo_writes();
        test_busy_ignore();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
verilog/exec_pkg.sv
verilog/alu_logic.sv
verilog/muldiv_ctrl.sv
verilog/step_counter.sv
verilog/muldiv_datapath.sv
verilog/hilo_regs.sv
verilog/exec_unit.sv
tests/exec_unit_asserts.sv
tests/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/exec_pkg.sv
      - verilog/alu_logic.sv
      - verilog/muldiv_ctrl.sv
      - verilog/step_counter.sv
      - verilog/muldiv_datapath.sv
      - verilog/hilo_regs.sv
      - verilog/exec_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/exec_unit_asserts.sv
      - tests/exec_unit_tb.sv
